// File: verilog/dw_pkg.sv
/* register map and fixed values of the rd50c controller
   word index is bus address bits 4:1, base 174000 */
`default_nettype none

package dw_pkg;

   // register word indices
   localparam logic [3:0] reg_id   = 4'd0;   // 174000 id
   localparam logic [3:0] reg_err  = 4'd1;   // 174002 error
   localparam logic [3:0] reg_sec  = 4'd3;   // 174006 sector
   localparam logic [3:0] reg_buf  = 4'd4;   // 174010 data buffer
   localparam logic [3:0] reg_cyl  = 4'd5;   // 174012 cylinder
   localparam logic [3:0] reg_hd   = 4'd6;   // 174014 head
   localparam logic [3:0] reg_cs2  = 4'd7;   // 174016 command/status 2
   localparam logic [3:0] reg_strs = 4'd8;   // 174020 status/reset

   localparam logic [15:0] dw_id = 16'o401;  // id word, rd50c

   // command codes
   localparam logic [7:0] cmd_recal = 8'o20;  // back to cylinder 0
   localparam logic [7:0] cmd_read  = 8'o40;
   localparam logic [7:0] cmd_write = 8'o60;

   // sector buffer
   localparam int buf_aw    = 8;
   localparam int buf_words = 256;          // 16-bit words, one sector

   // disk geometry, 16 sectors x 8 heads x 1024 cylinders
   localparam int cyl_w = 10;
   localparam int hd_w  = 3;
   localparam int sec_w = 5;
   localparam int chs_w = 17;               // cyl, hd, 4 bits of sector

endpackage

`default_nettype wire

// File: verilog/dw_bus_regs.sv
/* wishbone classic slave, every access takes exactly 2 cycles
   writes need wb_sel_i = 11, byte writes are dropped, adr bit 0 is ignored */
`timescale 1ns/1ns
`default_nettype none

module dw_bus_regs (
   input  wire                       wb_clk_i,
   input  wire                       wb_rst_i,
   input  wire  [4:0]                wb_adr_i,
   input  wire  [15:0]               wb_dat_i,
   output logic [15:0]               wb_dat_o,
   input  wire                       wb_cyc_i,
   input  wire                       wb_stb_i,
   input  wire                       wb_we_i,
   input  wire  [1:0]                wb_sel_i,
   output logic                      wb_ack_o,
   output logic [dw_pkg::cyl_w-1:0]  cyl_o,
   output logic [dw_pkg::hd_w-1:0]   hd_o,
   output logic [dw_pkg::sec_w-1:0]  sec_o,
   output logic                      ide_o,
   output logic                      soft_rst_o,
   output logic                      cmd_go_o,
   output logic [7:0]                cmd_code_o,
   output logic                      done_clr_o,
   output logic                      buf_rd_o,
   output logic                      buf_wr_o,
   output logic [15:0]               buf_wdat_o,
   input  wire  [15:0]               buf_rdat_i,
   input  wire                       done_i,
   input  wire                       drq_i,
   input  wire                       busy_i,
   input  wire                       cmderr_i,
   input  wire                       wrerr_i
);

   logic [3:0]  widx;     // register word index
   logic        strobe;   // first cycle of an access
   logic        rd_stb;   // read, strobe cycle
   logic        wr_ok;    // full word write, strobe cycle
   logic        ready;
   logic [15:0] rd_word;

   assign widx   = wb_adr_i[4:1];
   assign strobe = wb_cyc_i & wb_stb_i & ~wb_ack_o;
   assign rd_stb = strobe & ~wb_we_i;
   assign wr_ok  = strobe & wb_we_i & (wb_sel_i == 2'b11);
   assign ready  = ~busy_i;

   //**************************************************
   //* bus handshake
   //**************************************************
   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         wb_ack_o <= 1'b0;
      end else begin
         wb_ack_o <= strobe;   // one cycle late, then drops
      end
   end

   // command and flag pulses
   assign cmd_go_o   = wr_ok & (widx == dw_pkg::reg_cs2);
   assign cmd_code_o = wb_dat_i[7:0];
   assign done_clr_o = (rd_stb | wr_ok) &
                       ((widx == dw_pkg::reg_sec) | (widx == dw_pkg::reg_cs2));

   // buffer host side
   assign buf_rd_o   = wb_ack_o & wb_cyc_i & wb_stb_i & ~wb_we_i &
                       (widx == dw_pkg::reg_buf);   // after data was sampled
   assign buf_wr_o   = wr_ok & (widx == dw_pkg::reg_buf);
   assign buf_wdat_o = wb_dat_i;

   //**************************************************
   //* chs and control registers
   //**************************************************
   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         cyl_o      <= '0;
         hd_o       <= '0;
         sec_o      <= '0;
         ide_o      <= 1'b0;
         soft_rst_o <= 1'b0;
      end else if (soft_rst_o) begin   // software reset cycle
         cyl_o      <= '0;
         hd_o       <= '0;
         sec_o      <= '0;
         ide_o      <= 1'b0;
         soft_rst_o <= 1'b0;
      end else begin
         soft_rst_o <= wr_ok & (widx == dw_pkg::reg_strs) & wb_dat_i[3];
         if (wr_ok) begin
            case (widx)
               dw_pkg::reg_sec:  sec_o <= wb_dat_i[dw_pkg::sec_w-1:0];  // 1-based
               dw_pkg::reg_cyl:  cyl_o <= wb_dat_i[dw_pkg::cyl_w-1:0];
               dw_pkg::reg_hd:   hd_o  <= wb_dat_i[dw_pkg::hd_w-1:0];
               dw_pkg::reg_strs: ide_o <= wb_dat_i[6];
               default: ;
            endcase
         end
      end
   end

   // read words
   always_comb begin
      case (widx)
         dw_pkg::reg_id:   rd_word = dw_pkg::dw_id;
         dw_pkg::reg_err:  rd_word = {5'b0, cmderr_i, 10'b0};
         dw_pkg::reg_sec:  rd_word = {11'b0, sec_o};
         dw_pkg::reg_buf:  rd_word = buf_rdat_i;   // word at host pointer
         dw_pkg::reg_cyl:  rd_word = {6'b0, cyl_o};
         dw_pkg::reg_hd:   rd_word = {13'b0, hd_o};
         dw_pkg::reg_cs2:  rd_word = {1'b0, ready, wrerr_i, ready, drq_i,
                                      2'b0, cmderr_i, 8'b0};
         dw_pkg::reg_strs: rd_word = {busy_i, 7'b0, 1'b1, ide_o, 5'b0, done_i};
         default:          rd_word = 16'h0000;
      endcase
   end

   always_ff @(posedge wb_clk_i) begin
      if (rd_stb) begin
         wb_dat_o <= rd_word;   // same edge as ack
      end
   end

endmodule

`default_nettype wire

// File: verilog/dw_sector_buf.sv
/* 256 x 16 sector buffer, host side walks an auto-increment pointer
   host and block store must not write in the same cycle */
`timescale 1ns/1ns
`default_nettype none

module dw_sector_buf (
   input  wire                        wb_clk_i,
   input  wire                        wb_rst_i,
   input  wire                        ptr_clr_i,
   input  wire                        host_rd_i,
   input  wire                        host_wr_i,
   input  wire  [15:0]                host_dat_i,
   output logic [15:0]                host_dat_o,
   output logic                       last_o,
   input  wire  [dw_pkg::buf_aw-1:0]  blk_buf_addr_i,
   input  wire                        blk_buf_we_i,
   input  wire  [15:0]                blk_buf_dat_i,
   output logic [15:0]                blk_buf_dat_o
);

   logic [15:0]               mem [0:dw_pkg::buf_words-1];
   logic [dw_pkg::buf_aw-1:0] ptr;       // host word pointer
   logic [dw_pkg::buf_aw-1:0] wr_addr;
   logic                      host_acc;

   assign host_acc = host_rd_i | host_wr_i;
   assign last_o   = host_acc & (&ptr);   // word 255

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         ptr <= '0;
      end else if (ptr_clr_i) begin
         ptr <= '0;
      end else if (host_acc) begin
         ptr <= ptr + 1'b1;   // wraps after 255
      end
   end

   // single write port, store only writes while its request is up
   assign wr_addr = blk_buf_we_i ? blk_buf_addr_i : ptr;

   always_ff @(posedge wb_clk_i) begin
      if (blk_buf_we_i | host_wr_i) begin
         mem[wr_addr] <= blk_buf_we_i ? blk_buf_dat_i : host_dat_i;
      end
   end

   assign host_dat_o    = mem[ptr];
   assign blk_buf_dat_o = mem[blk_buf_addr_i];

endmodule

`default_nettype wire

// File: verilog/dw_cmd_seq.sv
/* runs recalibrate, read and write against the block store
   block address = bank offset + cyl*128 + hd*16 + (sec-1) mod 16 */
`timescale 1ns/1ns
`default_nettype none

module dw_cmd_seq #(
   parameter int blk_aw = 27
) (
   input  wire                       wb_clk_i,
   input  wire                       wb_rst_i,
   input  wire                       soft_rst_i,
   input  wire                       cmd_go_i,
   input  wire  [7:0]                cmd_code_i,
   input  wire                       done_clr_i,
   input  wire  [dw_pkg::cyl_w-1:0]  cyl_i,
   input  wire  [dw_pkg::hd_w-1:0]   hd_i,
   input  wire  [dw_pkg::sec_w-1:0]  sec_i,
   input  wire  [blk_aw-1:0]         bank_offset_i,
   input  wire                       last_i,
   output logic                      ptr_clr_o,
   output logic                      done_o,
   output logic                      drq_o,
   output logic                      busy_o,
   output logic                      cmderr_o,
   output logic                      wrerr_o,
   output logic                      blk_rd_o,
   output logic                      blk_wr_o,
   output logic [blk_aw-1:0]         blk_addr_o,
   input  wire                       blk_done_i,
   input  wire                       blk_err_i
);

   localparam logic [1:0] s_idle  = 2'd0;
   localparam logic [1:0] s_rd    = 2'd1;   // read request out
   localparam logic [1:0] s_wfill = 2'd2;   // host filling buffer
   localparam logic [1:0] s_wr    = 2'd3;   // write request out

   logic [1:0]               state;
   logic                     accept;     // command taken
   logic [dw_pkg::sec_w-1:0] sec_m1;     // sectors count from 1
   logic [dw_pkg::chs_w-1:0] chs;

   assign accept    = cmd_go_i & (state == s_idle);   // busy drops new commands
   assign ptr_clr_o = soft_rst_i | accept;
   assign sec_m1    = sec_i - 1'b1;
   assign chs       = {cyl_i, hd_i, sec_m1[3:0]};

   // address frozen for the whole command
   always_ff @(posedge wb_clk_i) begin
      if (accept) begin
         blk_addr_o <= bank_offset_i + blk_aw'(chs);
      end
   end

   //**************************************************
   //* command sequencer
   //**************************************************
   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         state    <= s_idle;
         done_o   <= 1'b1;
         drq_o    <= 1'b0;
         busy_o   <= 1'b0;
         cmderr_o <= 1'b0;
         wrerr_o  <= 1'b0;
         blk_rd_o <= 1'b0;
         blk_wr_o <= 1'b0;
      end else if (soft_rst_i) begin
         state    <= s_idle;
         done_o   <= 1'b1;
         drq_o    <= 1'b0;
         busy_o   <= 1'b0;
         cmderr_o <= 1'b0;
         wrerr_o  <= 1'b0;
         blk_rd_o <= 1'b0;
         blk_wr_o <= 1'b0;
      end else begin
         if (done_clr_i) done_o <= 1'b0;   // sets below win
         case (state)
            s_idle: begin
               if (drq_o & last_i) begin   // host read the whole sector
                  drq_o  <= 1'b0;
                  done_o <= 1'b1;
               end
               if (cmd_go_i) begin
                  cmderr_o <= 1'b0;
                  wrerr_o  <= 1'b0;
                  drq_o    <= 1'b0;
                  case (cmd_code_i)
                     dw_pkg::cmd_recal: done_o <= 1'b1;   // nothing to seek
                     dw_pkg::cmd_read: begin
                        busy_o   <= 1'b1;
                        blk_rd_o <= 1'b1;
                        state    <= s_rd;
                     end
                     dw_pkg::cmd_write: begin
                        drq_o <= 1'b1;   // ask host for data
                        state <= s_wfill;
                     end
                     default: cmderr_o <= 1'b1;
                  endcase
               end
            end
            s_rd: begin
               if (blk_done_i) begin
                  blk_rd_o <= 1'b0;
                  busy_o   <= 1'b0;
                  state    <= s_idle;
                  if (blk_err_i) cmderr_o <= 1'b1;
                  else drq_o <= 1'b1;   // sector in buffer
               end
            end
            s_wfill: begin
               if (last_i) begin   // 256th word written
                  drq_o    <= 1'b0;
                  busy_o   <= 1'b1;
                  blk_wr_o <= 1'b1;
                  state    <= s_wr;
               end
            end
            default: begin   // s_wr
               if (blk_done_i) begin
                  blk_wr_o <= 1'b0;
                  busy_o   <= 1'b0;
                  done_o   <= 1'b1;
                  wrerr_o  <= blk_err_i;
                  state    <= s_idle;
               end
            end
         endcase
      end
   end

endmodule

`default_nettype wire

// File: verilog/dw_irq.sv
/* one interrupt per done/drq event, rearmed only after iack falls */
`timescale 1ns/1ns
`default_nettype none

module dw_irq (
   input  wire  wb_clk_i,
   input  wire  wb_rst_i,
   input  wire  soft_rst_i,
   input  wire  ide_i,
   input  wire  done_i,
   input  wire  drq_i,
   input  wire  iack_i,
   output logic irq_o
);

   localparam logic [1:0] i_idle = 2'd0;
   localparam logic [1:0] i_req  = 2'd1;   // irq out
   localparam logic [1:0] i_wait = 2'd2;   // acked, wait iack low

   logic [1:0] state;

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         state <= i_idle;
         irq_o <= 1'b0;
      end else if (soft_rst_i) begin
         state <= i_idle;
         irq_o <= 1'b0;
      end else begin
         case (state)
            i_idle: begin
               if (ide_i & (done_i | drq_i)) begin
                  irq_o <= 1'b1;
                  state <= i_req;
               end
            end
            i_req: begin
               if (~ide_i) begin   // withdrawn
                  irq_o <= 1'b0;
                  state <= i_idle;
               end else if (iack_i) begin
                  irq_o <= 1'b0;
                  state <= i_wait;
               end
            end
            default: begin
               if (~iack_i) state <= i_idle;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

// File: verilog/dw_top.sv
/* rd50c disk controller, wishbone slave with an external block store
   the store may touch blk_buf_* only while blk_rd_o or blk_wr_o is high */
`timescale 1ns/1ns
`default_nettype none

module dw_top #(
   parameter int blk_aw = 27
) (
   input  wire                        wb_clk_i,
   input  wire                        wb_rst_i,
   input  wire  [4:0]                 wb_adr_i,
   input  wire  [15:0]                wb_dat_i,
   output logic [15:0]                wb_dat_o,
   input  wire                        wb_cyc_i,
   input  wire                        wb_stb_i,
   input  wire                        wb_we_i,
   input  wire  [1:0]                 wb_sel_i,
   output logic                       wb_ack_o,
   output logic                       irq_o,
   input  wire                        iack_i,
   input  wire  [blk_aw-1:0]          bank_offset_i,   // start of disk image
   output logic                       blk_rd_o,
   output logic                       blk_wr_o,
   output logic [blk_aw-1:0]          blk_addr_o,
   input  wire                        blk_done_i,
   input  wire                        blk_err_i,
   input  wire  [dw_pkg::buf_aw-1:0]  blk_buf_addr_i,
   input  wire                        blk_buf_we_i,
   input  wire  [15:0]                blk_buf_dat_i,
   output logic [15:0]                blk_buf_dat_o
);

   logic [dw_pkg::cyl_w-1:0] cyl;
   logic [dw_pkg::hd_w-1:0]  hd;
   logic [dw_pkg::sec_w-1:0] sec;
   logic                     ide;
   logic                     soft_rst;
   logic                     cmd_go;
   logic [7:0]               cmd_code;
   logic                     done_clr;
   logic                     buf_rd;
   logic                     buf_wr;
   logic [15:0]              buf_wdat;
   logic [15:0]              buf_rdat;
   logic                     last;      // host hit word 255
   logic                     ptr_clr;
   logic                     done;
   logic                     drq;
   logic                     busy;
   logic                     cmderr;
   logic                     wrerr;

   dw_bus_regs dw_bus_regs_inst (
      .wb_clk_i, .wb_rst_i, .wb_adr_i, .wb_dat_i, .wb_dat_o,
      .wb_cyc_i, .wb_stb_i, .wb_we_i, .wb_sel_i, .wb_ack_o,
      .cyl_o(cyl), .hd_o(hd), .sec_o(sec), .ide_o(ide),
      .soft_rst_o(soft_rst), .cmd_go_o(cmd_go), .cmd_code_o(cmd_code),
      .done_clr_o(done_clr),
      .buf_rd_o(buf_rd), .buf_wr_o(buf_wr),
      .buf_wdat_o(buf_wdat), .buf_rdat_i(buf_rdat),
      .done_i(done), .drq_i(drq), .busy_i(busy),
      .cmderr_i(cmderr), .wrerr_i(wrerr)
   );

   dw_sector_buf dw_sector_buf_inst (
      .wb_clk_i, .wb_rst_i,
      .ptr_clr_i(ptr_clr), .host_rd_i(buf_rd), .host_wr_i(buf_wr),
      .host_dat_i(buf_wdat), .host_dat_o(buf_rdat), .last_o(last),
      .blk_buf_addr_i, .blk_buf_we_i, .blk_buf_dat_i, .blk_buf_dat_o
   );

   dw_cmd_seq #(.blk_aw(blk_aw)) dw_cmd_seq_inst (
      .wb_clk_i, .wb_rst_i, .soft_rst_i(soft_rst),
      .cmd_go_i(cmd_go), .cmd_code_i(cmd_code), .done_clr_i(done_clr),
      .cyl_i(cyl), .hd_i(hd), .sec_i(sec), .bank_offset_i,
      .last_i(last), .ptr_clr_o(ptr_clr),
      .done_o(done), .drq_o(drq), .busy_o(busy),
      .cmderr_o(cmderr), .wrerr_o(wrerr),
      .blk_rd_o, .blk_wr_o, .blk_addr_o, .blk_done_i, .blk_err_i
   );

   dw_irq dw_irq_inst (
      .wb_clk_i, .wb_rst_i, .soft_rst_i(soft_rst),
      .ide_i(ide), .done_i(done), .drq_i(drq),
      .iack_i, .irq_o
   );

endmodule

`default_nettype wire

// File: tb/tb_clkgen.sv
/* free running clock, reset high from time zero for rst_cycles rising edges */
`timescale 1ns/1ns
`default_nettype none

module tb_clkgen #(
   parameter int period     = 20,
   parameter int rst_cycles = 3
) (
   output logic clk_o,
   output logic rst_o
);

   initial begin
      clk_o = 1'b0;
      forever #(period / 2) clk_o = ~clk_o;
   end

   initial begin
      rst_o = 1'b1;
      repeat (rst_cycles) @(posedge clk_o);
      @(negedge clk_o);   // release away from the sampling edge
      rst_o = 1'b0;
   end

endmodule

`default_nettype wire

// File: tb/tb_blk_store.sv
/* behavioral block store, one request at a time, 1 to 8 cycles before the transfer
   read data is block address xor word index, written words go to a sparse map */
`timescale 1ns/1ns
`default_nettype none

module tb_blk_store #(
   parameter int blk_aw = 27
) (
   input  wire                clk_i,
   input  wire                rd_i,
   input  wire                wr_i,
   input  wire  [blk_aw-1:0]  addr_i,
   input  wire                err_en_i,     // error injection on/off
   input  wire  [blk_aw-1:0]  err_addr_i,   // block that fails
   output logic               done_o,
   output logic               err_o,
   output logic [7:0]         buf_addr_o,
   output logic               buf_we_o,
   output logic [15:0]        buf_dat_o,
   input  wire  [15:0]        buf_dat_i
);

   logic [15:0] wmem [logic [blk_aw+7:0]];   // key {block, word}
   int          delay;

   // stored word of a block, dead marks a word never written
   function automatic logic [15:0] word_at(input logic [blk_aw-1:0] blk, input int idx);
      logic [blk_aw+7:0] key;
      key = {blk, 8'(idx)};
      if (wmem.exists(key)) begin
         return wmem[key];
      end
      return 16'hdead;
   endfunction

   //**************************************************
   //* request service, all outputs move on negedge
   //**************************************************
   initial begin
      done_o     = 1'b0;
      err_o      = 1'b0;
      buf_addr_o = '0;
      buf_we_o   = 1'b0;
      buf_dat_o  = '0;
      forever begin
         @(negedge clk_i);
         if (rd_i | wr_i) begin
            delay = 1 + int'($urandom % 8);   // seek time
            repeat (delay) @(negedge clk_i);
            for (int i = 0; i < 256; i++) begin
               buf_addr_o = 8'(i);
               if (rd_i) begin
                  buf_dat_o = 16'(addr_i) ^ 16'(i);
                  buf_we_o  = 1'b1;
                  @(negedge clk_i);
               end else begin
                  @(negedge clk_i);   // buffer read port is combinational
                  wmem[{addr_i, 8'(i)}] = buf_dat_i;
               end
            end
            buf_we_o = 1'b0;
            done_o   = 1'b1;
            err_o    = err_en_i & (addr_i == err_addr_i);
            do begin
               @(negedge clk_i);
            end while (rd_i | wr_i);   // hold done until request drops
            done_o = 1'b0;
            err_o  = 1'b0;
         end
      end
   end

endmodule

`default_nettype wire

// File: tb/dw_tb.sv
/* directed tests of the rd50c controller against a random latency block store
   all dut inputs move on the falling edge, a bus access takes 2 cycles */
`timescale 1ns/1ns
`default_nettype none

module dw_tb;

   localparam int blk_aw   = 27;
   localparam int period   = 20;
   localparam int poll_max = 400;   // status polls before giving up
   // 7 store transfers, 3 sectors over the bus, plus polling slack
   localparam int xfer_cyc = 256 + 16;
   localparam int run_cyc  = 8 * xfer_cyc + 3 * 2 * 256 + 4000;
   localparam longint timeout_ns = longint'(run_cyc) * period;

   logic              wb_clk_i;
   logic              wb_rst_i;
   logic [4:0]        wb_adr_i;
   logic [15:0]       wb_dat_i;
   logic [15:0]       wb_dat_o;
   logic              wb_cyc_i;
   logic              wb_stb_i;
   logic              wb_we_i;
   logic [1:0]        wb_sel_i;
   logic              wb_ack_o;
   logic              irq;
   logic              iack;
   logic [blk_aw-1:0] bank;       // disk image base
   logic              blk_rd;
   logic              blk_wr;
   logic [blk_aw-1:0] blk_addr;
   logic              blk_done;
   logic              blk_err;
   logic [7:0]        blk_buf_addr;
   logic              blk_buf_we;
   logic [15:0]       blk_buf_wdat;
   logic [15:0]       blk_buf_rdat;
   logic              err_en;
   logic [blk_aw-1:0] err_addr;
   logic [15:0]       wr_words [0:255];   // last sector sent
   int                errors;
   int                checks;
   int unsigned       seed_val;

   tb_clkgen #(.period(period), .rst_cycles(3)) clkgen_inst (
      .clk_o(wb_clk_i), .rst_o(wb_rst_i)
   );

   tb_blk_store #(.blk_aw(blk_aw)) blk_store_inst (
      .clk_i(wb_clk_i), .rd_i(blk_rd), .wr_i(blk_wr), .addr_i(blk_addr),
      .err_en_i(err_en), .err_addr_i(err_addr),
      .done_o(blk_done), .err_o(blk_err),
      .buf_addr_o(blk_buf_addr), .buf_we_o(blk_buf_we),
      .buf_dat_o(blk_buf_wdat), .buf_dat_i(blk_buf_rdat)
   );

   dw_top #(.blk_aw(blk_aw)) dw_top_inst (
      .wb_clk_i(wb_clk_i), .wb_rst_i(wb_rst_i), .wb_adr_i(wb_adr_i),
      .wb_dat_i(wb_dat_i), .wb_dat_o(wb_dat_o), .wb_cyc_i(wb_cyc_i),
      .wb_stb_i(wb_stb_i), .wb_we_i(wb_we_i), .wb_sel_i(wb_sel_i),
      .wb_ack_o(wb_ack_o), .irq_o(irq), .iack_i(iack), .bank_offset_i(bank),
      .blk_rd_o(blk_rd), .blk_wr_o(blk_wr), .blk_addr_o(blk_addr),
      .blk_done_i(blk_done), .blk_err_i(blk_err),
      .blk_buf_addr_i(blk_buf_addr), .blk_buf_we_i(blk_buf_we),
      .blk_buf_dat_i(blk_buf_wdat), .blk_buf_dat_o(blk_buf_rdat)
   );

   //**************************************************
   //* checking and bus helpers
   //**************************************************
   task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("FAIL %0t ns %s got %0h expected %0h", $time, name, got, exp);
      end
   endtask

   task automatic report_error(input string what);
      errors++;
      $display("ERROR %0t ns %s", $time, what);
   endtask

   // one classic cycle, entered and left on a falling edge
   task automatic bus_cycle(input logic we, input logic [3:0] idx, input logic [15:0] wdat,
                            output logic [15:0] rdat);
      int n;
      wb_adr_i = {idx, 1'b0};
      wb_dat_i = wdat;
      wb_we_i  = we;
      wb_sel_i = 2'b11;
      wb_cyc_i = 1'b1;
      wb_stb_i = 1'b1;
      rdat     = 16'h0000;
      n        = 0;
      do begin
         @(negedge wb_clk_i);
         n++;
      end while (!wb_ack_o && n < 4);
      if (wb_ack_o && n == 1) begin
         rdat = wb_dat_o;
      end else begin
         report_error("wishbone ack did not come one cycle after the strobe");
      end
      @(negedge wb_clk_i);   // stb held over the ack edge
      if (wb_ack_o) begin
         report_error("wishbone ack held longer than one cycle");
      end
      wb_cyc_i = 1'b0;
      wb_stb_i = 1'b0;
      wb_we_i  = 1'b0;
   endtask

   task automatic write_reg(input logic [3:0] idx, input logic [15:0] data);
      logic [15:0] dummy;
      bus_cycle(1'b1, idx, data, dummy);
   endtask

   task automatic read_reg(input logic [3:0] idx, output logic [15:0] data);
      bus_cycle(1'b0, idx, 16'h0000, data);
   endtask

   task automatic expect_reg(input string name, input logic [3:0] idx, input logic [15:0] exp);
      logic [15:0] d;
      read_reg(idx, d);
      check_val(name, 32'(d), 32'(exp));
   endtask

   task automatic poll_idle();
      logic [15:0] s;
      int n;
      n = 0;
      do begin
         read_reg(dw_pkg::reg_strs, s);
         n++;
      end while (s[15] && n < poll_max);
      if (s[15]) begin
         report_error("controller stayed busy, store never finished");
      end
   endtask

   task automatic await_irq(input logic level);
      int n;
      n = 0;
      while (irq !== level && n < 10) begin
         @(negedge wb_clk_i);
         n++;
      end
      if (irq !== level) begin
         report_error("irq did not reach the expected level");
      end
   endtask

   // block = bank + cyl*128 + hd*16 + (sec-1) mod 16
   function automatic logic [blk_aw-1:0] block_of(input int cyl, input int hd, input int sec);
      return bank + blk_aw'(cyl * 128 + hd * 16 + (sec + 15) % 16);
   endfunction

   task automatic set_chs(input int cyl, input int hd, input int sec);
      write_reg(dw_pkg::reg_cyl, 16'(cyl));
      write_reg(dw_pkg::reg_hd, 16'(hd));
      write_reg(dw_pkg::reg_sec, 16'(sec));
   endtask

   task automatic read_cmd(input int cyl, input int hd, input int sec);
      set_chs(cyl, hd, sec);
      write_reg(dw_pkg::reg_cs2, {8'h00, dw_pkg::cmd_read});
      if (blk_rd !== 1'b1) begin
         report_error("read command raised no store request");
      end
      check_val("blk_addr_o", 32'(blk_addr), 32'(block_of(cyl, hd, sec)));
      poll_idle();
   endtask

   //**************************************************
   //* directed tests
   //**************************************************
   task automatic reset_values();
      expect_reg("DWID", dw_pkg::reg_id, dw_pkg::dw_id);
      expect_reg("DWSTRS", dw_pkg::reg_strs, 16'h0081);   // done, bit 7
      check_val("irq_o", 32'(irq), 32'd0);
   endtask

   task automatic chs_registers();
      write_reg(dw_pkg::reg_cyl, 16'hffff);
      expect_reg("DWCYL", dw_pkg::reg_cyl, 16'h03ff);
      write_reg(dw_pkg::reg_hd, 16'hffff);
      expect_reg("DWHD", dw_pkg::reg_hd, 16'h0007);
      write_reg(dw_pkg::reg_sec, 16'hffff);
      expect_reg("DWSEC", dw_pkg::reg_sec, 16'h001f);
      read_cmd(5, 3, 1);      // sector 1 -> word 0 of track
      read_cmd(1023, 7, 16);  // top of the 17-bit space
      read_cmd(2, 0, 17);     // wraps mod 16
   endtask

   task automatic read_sector();
      logic [blk_aw-1:0] a;
      logic [15:0]       d;
      a = block_of(12, 2, 7);
      read_cmd(12, 2, 7);
      expect_reg("DWCS2", dw_pkg::reg_cs2, 16'h5800);   // drq, ready
      for (int i = 0; i < 256; i++) begin
         if (i == 255) begin
            expect_reg("DWCS2", dw_pkg::reg_cs2, 16'h5800);
            expect_reg("DWSTRS", dw_pkg::reg_strs, 16'h0080);   // not done yet
         end
         read_reg(dw_pkg::reg_buf, d);
         check_val("DWBUF", 32'(d), 32'(16'(a) ^ 16'(i)));
      end
      expect_reg("DWSTRS", dw_pkg::reg_strs, 16'h0081);   // done after last word
      expect_reg("DWCS2", dw_pkg::reg_cs2, 16'h5000);
   endtask

   task automatic write_sector(input int cyl, input int hd, input int sec, input logic inject);
      logic [blk_aw-1:0] a;
      a        = block_of(cyl, hd, sec);
      err_addr = a;
      err_en   = inject;
      set_chs(cyl, hd, sec);
      write_reg(dw_pkg::reg_cs2, {8'h00, dw_pkg::cmd_write});
      expect_reg("DWCS2", dw_pkg::reg_cs2, 16'h5800);   // drq asks for data
      for (int i = 0; i < 256; i++) begin
         if (i == 255 && blk_wr !== 1'b0) begin
            report_error("store write request before the buffer was full");
         end
         wr_words[i] = 16'($urandom);
         write_reg(dw_pkg::reg_buf, wr_words[i]);
      end
      if (blk_wr !== 1'b1) begin
         report_error("full buffer raised no store write request");
      end
      check_val("blk_addr_o", 32'(blk_addr), 32'(a));
      poll_idle();
      expect_reg("DWSTRS", dw_pkg::reg_strs, 16'h0081);
      expect_reg("DWCS2", dw_pkg::reg_cs2, inject ? 16'h7000 : 16'h5000);   // wrerr
      if (!inject) begin
         for (int i = 0; i < 256; i++) begin
            check_val("store word", 32'(blk_store_inst.word_at(a, i)), 32'(wr_words[i]));
         end
      end
      err_en = 1'b0;
   endtask

   task automatic command_errors();
      write_reg(dw_pkg::reg_cs2, 16'o77);   // no such command
      expect_reg("DWERR", dw_pkg::reg_err, 16'h0400);
      expect_reg("DWCS2", dw_pkg::reg_cs2, 16'h5100);
      write_reg(dw_pkg::reg_cs2, {8'h00, dw_pkg::cmd_recal});
      expect_reg("DWERR", dw_pkg::reg_err, 16'h0000);
      err_addr = block_of(40, 1, 3);
      err_en   = 1'b1;
      read_cmd(40, 1, 3);
      err_en   = 1'b0;
      expect_reg("DWERR", dw_pkg::reg_err, 16'h0400);
      expect_reg("DWCS2", dw_pkg::reg_cs2, 16'h5100);   // no drq on error
      write_reg(dw_pkg::reg_cs2, {8'h00, dw_pkg::cmd_recal});
      expect_reg("DWERR", dw_pkg::reg_err, 16'h0000);
   endtask

   task automatic interrupt_ack();
      expect_reg("DWCS2", dw_pkg::reg_cs2, 16'h5000);   // this read clears done
      write_reg(dw_pkg::reg_strs, 16'h0040);            // ide on
      check_val("irq_o", 32'(irq), 32'd0);
      write_reg(dw_pkg::reg_cs2, {8'h00, dw_pkg::cmd_recal});
      await_irq(1'b1);
      iack = 1'b1;
      @(negedge wb_clk_i);
      check_val("irq_o", 32'(irq), 32'd0);   // one cycle after iack
      repeat (5) begin
         @(negedge wb_clk_i);
         check_val("irq_o", 32'(irq), 32'd0);
      end
      iack = 1'b0;
      await_irq(1'b1);   // done still set, asks again
      write_reg(dw_pkg::reg_strs, 16'h0008);   // soft reset
      reset_values();
      expect_reg("DWCYL", dw_pkg::reg_cyl, 16'h0000);
   endtask

   //**************************************************
   //* main sequence and watchdog
   //**************************************************
   initial begin
      wb_adr_i = '0;
      wb_dat_i = '0;
      wb_cyc_i = 1'b0;
      wb_stb_i = 1'b0;
      wb_we_i  = 1'b0;
      wb_sel_i = 2'b00;
      iack     = 1'b0;
      bank     = 27'h0520000;
      err_en   = 1'b0;
      err_addr = '0;
      errors   = 0;
      checks   = 0;
      seed_val = $urandom(32'hdab3);
      repeat (2) @(negedge wb_clk_i);
      while (wb_rst_i) @(negedge wb_clk_i);
      reset_values();
      chs_registers();
      read_sector();
      write_sector(100, 5, 16, 1'b0);
      write_sector(700, 4, 9, 1'b1);
      command_errors();
      interrupt_ack();
      $display("summary: %0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

   initial begin
      #(timeout_ns);
      $display("ERROR %0t ns watchdog expired, tests did not finish", $time);
      $display("** FAIL **");
      $finish;
   end

endmodule

`default_nettype wire

// File: build.f
verilog/dw_pkg.sv
verilog/dw_bus_regs.sv
verilog/dw_sector_buf.sv
verilog/dw_cmd_seq.sv
verilog/dw_irq.sv
verilog/dw_top.sv
tb/tb_clkgen.sv
tb/tb_blk_store.sv
tb/dw_tb.sv

// File: Makefile
# Verilator flow for the RD50C controller testbench

VERILATOR  ?= verilator
TOP        ?= dw_tb
RTL_TOP    ?= dw_top
FILELIST   ?= build.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only
RTL_SRCS   ?= verilog/dw_pkg.sv verilog/dw_bus_regs.sv verilog/dw_sector_buf.sv \
              verilog/dw_cmd_seq.sv verilog/dw_irq.sv verilog/dw_top.sv
PASS_MSG   ?= ** PASS **

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# the exit status comes from the search for the pass line
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qxF '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJ_DIR)
